/* Makefile */
VERILATOR ?= verilator
TOP       := tb_histogramTop
FILELIST  := compile.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  := +verilator+error+limit+100
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) hist_params.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^RESULT: PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* binCountRam.sv */
`timescale 1ns/1ps
`include "hist_params.svh"

module binCountRam (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 wrEn,
    input  logic                 firstOfFrame,
    input  logic                 lastOfFrame,
    input  logic                 frameDone,
    input  hist_pkg::binAddr_t   sampleBin,
    input  hist_pkg::pixelIdx_t  pixel,
    output hist_pkg::binCount_t  binCount,
    output logic                 s1Valid,
    output logic                 s1First,
    output logic                 s1Last,
    output hist_pkg::binAddr_t   s1Bin,
    output hist_pkg::pixelIdx_t  s1Pixel
);

    localparam int RamDepth = `HIST_PIXEL_NUM * `HIST_BINS_PER_PIXEL;

    // one count per pixel and bin
    hist_pkg::binCount_t countMem [RamDepth];
    // entry holds a count of the current frame
    logic [RamDepth-1:0] entryValid;

    hist_pkg::ramAddr_t  ramAddr;
    logic                entryHit;
    hist_pkg::binCount_t newCount;

    // pixel picks the histogram, bin the word in it
    assign ramAddr = {pixel, sampleBin};

    // while frameDone is high the old frame is already treated as empty
    assign entryHit = entryValid[ramAddr] && !frameDone;

    // first hit of the frame starts at one
    assign newCount = entryHit ? hist_pkg::binCount_t'(countMem[ramAddr] + 1'b1)
                               : hist_pkg::binCount_t'(1);

    // read-modify-write, same edge as the strobe
    always_ff @(posedge clk) begin
        if (wrEn) begin
            countMem[ramAddr] <= newCount;
        end
    end

    // bulk clear after the frame, a fresh write still marks its entry
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            entryValid <= '0;
        end
        else begin
            if (frameDone) begin
                entryValid <= '0;
            end
            if (wrEn) begin
                entryValid[ramAddr] <= 1'b1;
            end
        end
    end

    // stage 1 control
    // binCount holds until the next accepted sample
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binCount <= '0;
            s1Valid  <= 1'b0;
            s1First  <= 1'b0;
            s1Last   <= 1'b0;
        end
        else begin
            s1Valid <= wrEn;
            if (wrEn) begin
                binCount <= newCount;
                s1First  <= firstOfFrame;
                s1Last   <= lastOfFrame;
            end
        end
    end

    // stage 1 payload
    always_ff @(posedge clk) begin
        if (wrEn) begin
            s1Bin   <= sampleBin;
            s1Pixel <= pixel;
        end
    end

endmodule

/* compile.f */
+incdir+.
hist_pkg.sv
frameSequencer.sv
binCountRam.sv
peakTracker.sv
peakWindow.sv
histogramTop.sv
tb_histogramTop_asserts.sv
tb_histogramTop.sv

/* frameSequencer.sv */
`timescale 1ns/1ps
`include "hist_params.svh"

module frameSequencer (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                wrEn,
    output hist_pkg::pixelIdx_t pixel,
    output logic                firstOfFrame,
    output logic                lastOfFrame,
    output logic                frameDone,
    output logic                frameParity
);

    // nested counters, sample is the fastest
    hist_pkg::sampleIdx_t sampleCnt;
    hist_pkg::pixelIdx_t  pixelCnt;
    hist_pkg::acqIdx_t    acqCnt;

    // wrap points of each counter
    logic lastSample;
    logic lastPixel;
    logic lastAcq;
    // the sample now presented closes the frame
    logic finalSample;

    assign lastSample = (sampleCnt == hist_pkg::sampleIdx_t'(`HIST_DATA_NUM - 1));
    assign lastPixel  = (pixelCnt == hist_pkg::pixelIdx_t'(`HIST_PIXEL_NUM - 1));
    assign lastAcq    = (acqCnt == hist_pkg::acqIdx_t'(`HIST_ACQ_NUM - 1));

    // flags describe the sample on the bus right now
    assign firstOfFrame = (acqCnt == '0) && (sampleCnt == '0);
    assign lastOfFrame  = lastAcq && lastSample;
    assign finalSample  = lastOfFrame && lastPixel;

    assign pixel = pixelCnt;

    // advance once per accepted sample
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
        end
        else if (wrEn) begin
            if (lastSample) begin
                sampleCnt <= '0;
                if (lastPixel) begin
                    pixelCnt <= '0;
                    // pass wraps back to 0 at frame end
                    acqCnt <= lastAcq ? '0 : acqCnt + 1'b1;
                end
                else begin
                    pixelCnt <= pixelCnt + 1'b1;
                end
            end
            else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    // one-cycle done pulse and parity flip on the final sample
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            frameDone   <= 1'b0;
            frameParity <= 1'b0;
        end
        else begin
            frameDone <= wrEn && finalSample;
            if (wrEn && finalSample) begin
                frameParity <= ~frameParity;
            end
        end
    end

endmodule

/* hist_params.svh */
`ifndef HIST_PARAMS_SVH
`define HIST_PARAMS_SVH

// coarse histogram geometry
// bin address width, 16 bins per pixel
`define HIST_NB 4

// fine time scale width
`define HIST_NP 8

// per-bin counter width
`define HIST_COUNT_W 8

// frame geometry
// samples per pixel in one acquisition pass
`define HIST_DATA_NUM 4
// pixels served by one count RAM
`define HIST_PIXEL_NUM 4
// passes per frame
`define HIST_ACQ_NUM 3

// half width of the fine search window
`define HIST_FINE_HALF 8

// bins held for each pixel
`define HIST_BINS_PER_PIXEL (1 << `HIST_NB)

// largest count is DATA_NUM * ACQ_NUM = 12, well inside COUNT_W

`endif

/* hist_pkg.sv */
`include "hist_params.svh"

package hist_pkg;

    // coarse bin index inside one pixel histogram
    typedef logic [`HIST_NB-1:0] binAddr_t;

    // hit count of one bin
    typedef logic [`HIST_COUNT_W-1:0] binCount_t;

    // pixel being filled
    typedef logic [$clog2(`HIST_PIXEL_NUM)-1:0] pixelIdx_t;

    // sample index inside one pixel burst
    typedef logic [$clog2(`HIST_DATA_NUM)-1:0] sampleIdx_t;

    // acquisition pass inside one frame
    typedef logic [$clog2(`HIST_ACQ_NUM)-1:0] acqIdx_t;

    // count RAM address, pixel in the upper bits
    typedef logic [$clog2(`HIST_PIXEL_NUM)+`HIST_NB-1:0] ramAddr_t;

    // position on the fine time scale
    typedef logic [`HIST_NP-1:0] fineBin_t;

endpackage

/* histogramTop.sv */
`timescale 1ns/1ps

module histogramTop (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 wrEn,
    input  hist_pkg::binAddr_t   sampleBin,
    output hist_pkg::binCount_t  binCount,
    output logic                 frameDone,
    output logic                 frameParity,
    output logic                 peakValid,
    output hist_pkg::pixelIdx_t  peakPixel,
    output hist_pkg::binAddr_t   peakBin,
    output hist_pkg::binCount_t  peakCount,
    output hist_pkg::fineBin_t   windowLow,
    output hist_pkg::fineBin_t   windowHigh
);

    // sequencer to RAM
    hist_pkg::pixelIdx_t pixel;
    logic                firstOfFrame;
    logic                lastOfFrame;

    // stage 1, RAM to tracker
    logic                s1Valid;
    logic                s1First;
    logic                s1Last;
    hist_pkg::binAddr_t  s1Bin;
    hist_pkg::pixelIdx_t s1Pixel;

    // stage 2, tracker to window
    logic                s2Valid;
    hist_pkg::pixelIdx_t s2Pixel;
    hist_pkg::binAddr_t  s2Bin;
    hist_pkg::binCount_t s2Count;

    frameSequencer i_frameSequencer (
        .clk          (clk),
        .combin_res   (combin_res),
        .wrEn         (wrEn),
        .pixel        (pixel),
        .firstOfFrame (firstOfFrame),
        .lastOfFrame  (lastOfFrame),
        .frameDone    (frameDone),
        .frameParity  (frameParity)
    );

    binCountRam i_binCountRam (
        .clk          (clk),
        .combin_res   (combin_res),
        .wrEn         (wrEn),
        .firstOfFrame (firstOfFrame),
        .lastOfFrame  (lastOfFrame),
        .frameDone    (frameDone),
        .sampleBin    (sampleBin),
        .pixel        (pixel),
        .binCount     (binCount),
        .s1Valid      (s1Valid),
        .s1First      (s1First),
        .s1Last       (s1Last),
        .s1Bin        (s1Bin),
        .s1Pixel      (s1Pixel)
    );

    // tracker reads the count straight from the stage 1 register
    peakTracker i_peakTracker (
        .clk        (clk),
        .combin_res (combin_res),
        .s1Valid    (s1Valid),
        .s1First    (s1First),
        .s1Last     (s1Last),
        .s1Bin      (s1Bin),
        .s1Pixel    (s1Pixel),
        .binCount   (binCount),
        .s2Valid    (s2Valid),
        .s2Pixel    (s2Pixel),
        .s2Bin      (s2Bin),
        .s2Count    (s2Count)
    );

    peakWindow i_peakWindow (
        .clk        (clk),
        .combin_res (combin_res),
        .s2Valid    (s2Valid),
        .s2Pixel    (s2Pixel),
        .s2Bin      (s2Bin),
        .s2Count    (s2Count),
        .peakValid  (peakValid),
        .peakPixel  (peakPixel),
        .peakBin    (peakBin),
        .peakCount  (peakCount),
        .windowLow  (windowLow),
        .windowHigh (windowHigh)
    );

endmodule

/* peakTracker.sv */
`timescale 1ns/1ps
`include "hist_params.svh"

module peakTracker (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 s1Valid,
    input  logic                 s1First,
    input  logic                 s1Last,
    input  hist_pkg::binAddr_t   s1Bin,
    input  hist_pkg::pixelIdx_t  s1Pixel,
    input  hist_pkg::binCount_t  binCount,
    output logic                 s2Valid,
    output hist_pkg::pixelIdx_t  s2Pixel,
    output hist_pkg::binAddr_t   s2Bin,
    output hist_pkg::binCount_t  s2Count
);

    // running maximum of each pixel and the bin that holds it
    hist_pkg::binCount_t maxCount [`HIST_PIXEL_NUM];
    hist_pkg::binAddr_t  maxBin   [`HIST_PIXEL_NUM];

    logic                takeNew;
    hist_pkg::binCount_t nextCount;
    hist_pkg::binAddr_t  nextBin;

    // first sample of the frame overwrites the stale entry
    // strict compare, a tie keeps the earlier bin
    assign takeNew   = s1First || (binCount > maxCount[s1Pixel]);
    assign nextCount = takeNew ? binCount : maxCount[s1Pixel];
    assign nextBin   = takeNew ? s1Bin : maxBin[s1Pixel];

    always_ff @(posedge clk) begin
        if (s1Valid) begin
            maxCount[s1Pixel] <= nextCount;
            maxBin[s1Pixel]   <= nextBin;
        end
    end

    // report strobe
    // only the last sample of a pixel in the frame reports
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            s2Valid <= 1'b0;
        end
        else begin
            s2Valid <= s1Valid && s1Last;
        end
    end

    // report carries the values including this last sample
    always_ff @(posedge clk) begin
        if (s1Valid && s1Last) begin
            s2Pixel <= s1Pixel;
            s2Bin   <= nextBin;
            s2Count <= nextCount;
        end
    end

endmodule

/* peakWindow.sv */
`timescale 1ns/1ps
`include "hist_params.svh"

module peakWindow (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 s2Valid,
    input  hist_pkg::pixelIdx_t  s2Pixel,
    input  hist_pkg::binAddr_t   s2Bin,
    input  hist_pkg::binCount_t  s2Count,
    output logic                 peakValid,
    output hist_pkg::pixelIdx_t  peakPixel,
    output hist_pkg::binAddr_t   peakBin,
    output hist_pkg::binCount_t  peakCount,
    output hist_pkg::fineBin_t   windowLow,
    output hist_pkg::fineBin_t   windowHigh
);

    localparam int FineShift = `HIST_NP - `HIST_NB;
    localparam int FineHalf  = `HIST_FINE_HALF;
    localparam int FineMax   = (1 << `HIST_NP) - 1;

    hist_pkg::fineBin_t centre;
    hist_pkg::fineBin_t lowNext;
    hist_pkg::fineBin_t highNext;

    // coarse bin scaled onto the fine axis
    assign centre = hist_pkg::fineBin_t'(s2Bin) << FineShift;

    // window of 2H around the centre, pushed inside 0..M
    always_comb begin
        if (centre < hist_pkg::fineBin_t'(FineHalf)) begin
            lowNext  = '0;
            highNext = hist_pkg::fineBin_t'(2 * FineHalf);
        end
        else if (centre > hist_pkg::fineBin_t'(FineMax - FineHalf)) begin
            lowNext  = hist_pkg::fineBin_t'(FineMax - 2 * FineHalf);
            highNext = hist_pkg::fineBin_t'(FineMax);
        end
        else begin
            lowNext  = centre - hist_pkg::fineBin_t'(FineHalf);
            highNext = centre + hist_pkg::fineBin_t'(FineHalf);
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peakValid <= 1'b0;
        end
        else begin
            peakValid <= s2Valid;
        end
    end

    // outputs only meaningful while peakValid is high
    always_ff @(posedge clk) begin
        if (s2Valid) begin
            peakPixel  <= s2Pixel;
            peakBin    <= s2Bin;
            peakCount  <= s2Count;
            windowLow  <= lowNext;
            windowHigh <= highNext;
        end
    end

endmodule

/* tb_histogramTop.sv */
`timescale 1ns/1ps
`include "hist_params.svh"

module tb_histogramTop;

    localparam int SamplesPerFrame = `HIST_DATA_NUM * `HIST_PIXEL_NUM * `HIST_ACQ_NUM;
    localparam int DirectedFrames  = 3;
    localparam int RandomFrames    = 5;
    localparam int WatchdogCycles  =
        (DirectedFrames + RandomFrames) * SamplesPerFrame * 2 + 200;

    logic                clk;
    logic                combin_res;
    logic                wrEn;
    hist_pkg::binAddr_t  sampleBin;
    hist_pkg::binCount_t binCount;
    logic                frameDone;
    logic                frameParity;
    logic                peakValid;
    hist_pkg::pixelIdx_t peakPixel;
    hist_pkg::binAddr_t  peakBin;
    hist_pkg::binCount_t peakCount;
    hist_pkg::fineBin_t  windowLow;
    hist_pkg::fineBin_t  windowHigh;

    // model state
    int mCount [`HIST_PIXEL_NUM][`HIST_BINS_PER_PIXEL];
    int mMax [`HIST_PIXEL_NUM];
    int mMaxBin [`HIST_PIXEL_NUM];
    int mSample;
    int mPixel;
    int mAcq;
    int mRepPixel;
    bit mReport;
    bit mFinal;

    // peak reports still due, oldest first
    int                  dueQ [$];
    hist_pkg::pixelIdx_t repPixelQ [$];
    hist_pkg::binAddr_t  repBinQ [$];
    hist_pkg::binCount_t repCountQ [$];

    int          cycle;
    int          valueErrors;
    int          protocolErrors;
    logic [31:0] lfsrState = 32'h8588;

    histogramTop i_histogramTop (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .sampleBin   (sampleBin),
        .binCount    (binCount),
        .frameDone   (frameDone),
        .frameParity (frameParity),
        .peakValid   (peakValid),
        .peakPixel   (peakPixel),
        .peakBin     (peakBin),
        .peakCount   (peakCount),
        .windowLow   (windowLow),
        .windowHigh  (windowHigh)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value     = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    // one accepted sample, returns the new bin count
    function hist_pkg::binCount_t stepModel(input hist_pkg::binAddr_t bin);
        int  px;
        int  b;
        int  c;
        bit  first;
        px    = mPixel;
        b     = int'(bin);
        first = (mAcq == 0) && (mSample == 0);
        mCount[px][b] = mCount[px][b] + 1;
        c = mCount[px][b];
        // strict compare keeps the older bin on a tie
        if (first || c > mMax[px]) begin
            mMax[px]    = c;
            mMaxBin[px] = b;
        end
        mReport   = (mAcq == `HIST_ACQ_NUM - 1) && (mSample == `HIST_DATA_NUM - 1);
        mFinal    = mReport && (px == `HIST_PIXEL_NUM - 1);
        mRepPixel = px;
        if (mSample == `HIST_DATA_NUM - 1) begin
            mSample = 0;
            if (mPixel == `HIST_PIXEL_NUM - 1) begin
                mPixel = 0;
                mAcq   = (mAcq + 1) % `HIST_ACQ_NUM;
            end
            else begin
                mPixel = mPixel + 1;
            end
        end
        else begin
            mSample = mSample + 1;
        end
        // next frame begins with empty histograms
        if (mFinal) begin
            for (int p = 0; p < `HIST_PIXEL_NUM; p++) begin
                for (int k = 0; k < `HIST_BINS_PER_PIXEL; k++) begin
                    mCount[p][k] = 0;
                end
            end
        end
        return hist_pkg::binCount_t'(c);
    endfunction

    // fine window edge around a coarse bin
    function automatic hist_pkg::fineBin_t windowEdge(input hist_pkg::binAddr_t bin,
                                                     input bit upper);
        int centre;
        int lo;
        int hi;
        centre = int'(bin) << (`HIST_NP - `HIST_NB);
        if (centre < `HIST_FINE_HALF) begin
            lo = 0;
            hi = 2 * `HIST_FINE_HALF;
        end
        else if (centre > (1 << `HIST_NP) - 1 - `HIST_FINE_HALF) begin
            hi = (1 << `HIST_NP) - 1;
            lo = hi - 2 * `HIST_FINE_HALF;
        end
        else begin
            lo = centre - `HIST_FINE_HALF;
            hi = centre + `HIST_FINE_HALF;
        end
        return upper ? hist_pkg::fineBin_t'(hi) : hist_pkg::fineBin_t'(lo);
    endfunction

    task automatic valueError(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        valueErrors++;
    endtask

    task automatic checkCount(input string name, input hist_pkg::binCount_t expected,
                              input hist_pkg::binCount_t actual);
        if (actual !== expected) valueError(name, 32'(expected), 32'(actual));
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) valueError(name, 32'(expected), 32'(actual));
    endtask

    task automatic checkPeak(input hist_pkg::pixelIdx_t expPixel,
                             input hist_pkg::binAddr_t expBin,
                             input hist_pkg::binCount_t expCount);
        if (peakPixel !== expPixel) valueError("peakPixel", 32'(expPixel), 32'(peakPixel));
        if (peakBin !== expBin) valueError("peakBin", 32'(expBin), 32'(peakBin));
        checkCount("peakCount", expCount, peakCount);
    endtask

    task automatic checkWindow(input hist_pkg::fineBin_t expLow,
                               input hist_pkg::fineBin_t expHigh);
        if (windowLow !== expLow) valueError("windowLow", 32'(expLow), 32'(windowLow));
        if (windowHigh !== expHigh) valueError("windowHigh", 32'(expHigh), 32'(windowHigh));
    endtask

    task automatic driveSample(input hist_pkg::binAddr_t bin);
        @(posedge clk);
        #1;
        wrEn      = 1'b1;
        sampleBin = bin;
    endtask

    task automatic driveIdle();
        @(posedge clk);
        #1;
        wrEn = 1'b0;
    endtask

    initial begin : clockGen
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // outputs are read at the falling edge
    initial begin : scoreboard
        logic                accepted;
        hist_pkg::binAddr_t  acceptedBin;
        hist_pkg::binCount_t expCount;
        logic                expDone;
        logic                expParity;
        accepted  = 1'b0;
        expCount  = '0;
        expParity = 1'b0;
        forever begin
            @(negedge clk);
            if (combin_res) begin
                cycle++;
                expDone = 1'b0;
                if (accepted) begin
                    expCount = stepModel(acceptedBin);
                    expDone  = mFinal;
                    if (mFinal) expParity = ~expParity;
                    // report shows two cycles after the counting edge
                    if (mReport) begin
                        dueQ.push_back(cycle + 2);
                        repPixelQ.push_back(hist_pkg::pixelIdx_t'(mRepPixel));
                        repBinQ.push_back(hist_pkg::binAddr_t'(mMaxBin[mRepPixel]));
                        repCountQ.push_back(hist_pkg::binCount_t'(mMax[mRepPixel]));
                    end
                end
                checkCount("binCount", expCount, binCount);
                checkFlag("frameParity", expParity, frameParity);
                if (frameDone !== expDone) begin
                    if (expDone) $display("frameDone missing after frame end at %0t", $time);
                    else $display("frameDone pulsed outside a frame end at %0t", $time);
                    protocolErrors++;
                end
                if (dueQ.size() != 0 && dueQ[0] == cycle) begin
                    if (peakValid !== 1'b1) begin
                        $display("peak report of pixel %0d missing at %0t", repPixelQ[0], $time);
                        protocolErrors++;
                    end
                    else begin
                        checkPeak(repPixelQ[0], repBinQ[0], repCountQ[0]);
                        checkWindow(windowEdge(repBinQ[0], 1'b0), windowEdge(repBinQ[0], 1'b1));
                    end
                    void'(dueQ.pop_front());
                    void'(repPixelQ.pop_front());
                    void'(repBinQ.pop_front());
                    void'(repCountQ.pop_front());
                end
                else if (peakValid !== 1'b0) begin
                    $display("peakValid high with no report due at %0t", $time);
                    protocolErrors++;
                end
            end
            // bus values now driven are taken at the next rising edge
            accepted    = wrEn && combin_res;
            acceptedBin = sampleBin;
        end
    end

    initial begin : watchdog
        repeat (WatchdogCycles) @(posedge clk);
        $display("timeout, run not finished after %0d cycles", WatchdogCycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : runTest
        int                 directedBins [DirectedFrames];
        int                 s;
        int                 p;
        int                 assertErrors;
        hist_pkg::binAddr_t bin;
        directedBins = '{0, 15, 7};
        wrEn       = 1'b0;
        sampleBin  = '0;
        combin_res = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        combin_res = 1'b1;
        // peaks at bin 0, bin 15 and a middle bin
        // last sample of each burst lands on a neighbour bin
        for (int f = 0; f < DirectedFrames; f++) begin
            for (int i = 0; i < SamplesPerFrame; i++) begin
                s = i % `HIST_DATA_NUM;
                p = (i / `HIST_DATA_NUM) % `HIST_PIXEL_NUM;
                if (s == `HIST_DATA_NUM - 1) bin = hist_pkg::binAddr_t'(directedBins[f] + p + 1);
                else bin = hist_pkg::binAddr_t'(directedBins[f]);
                driveSample(bin);
            end
        end
        // random bins, about one idle cycle in four
        for (int f = 0; f < RandomFrames; f++) begin
            for (int i = 0; i < SamplesPerFrame; i++) begin
                while (randBits(2) == 32'd0) driveIdle();
                driveSample(hist_pkg::binAddr_t'(randBits(`HIST_NB)));
            end
        end
        driveIdle();
        // scoreboard takes in the last sample at this falling edge
        @(negedge clk);
        #1;
        while (dueQ.size() != 0) begin
            @(negedge clk);
            #1;
        end
        // a short tail to catch stray pulses
        repeat (2) @(negedge clk);
        #1;
        assertErrors = i_histogramTop.i_histogramAsserts.failCount;
        $display("errors: %0d value, %0d protocol, %0d assertion",
                 valueErrors, protocolErrors, assertErrors);
        if (valueErrors + protocolErrors + assertErrors == 0) begin
            $display("RESULT: PASS");
        end
        else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb_histogramTop_asserts.sv */
`timescale 1ns/1ps

module histogramAsserts (
    input logic clk,
    input logic combin_res,
    input logic frameDone,
    input logic frameParity,
    input logic peakValid
);

    // number of assertion failures, read back by the testbench
    int failCount = 0;

    // registered strobes stay low while reset is held
    resetQuiet: assert property (@(posedge clk) !combin_res |=> !peakValid && !frameDone)
        else begin
            failCount++;
            $error("peakValid or frameDone high during reset");
        end

    // done is a single-cycle pulse
    singleDone: assert property (@(posedge clk) disable iff (!combin_res)
        frameDone |=> !frameDone)
        else begin
            failCount++;
            $error("frameDone high on two consecutive cycles");
        end

    // parity only moves together with the done pulse
    parityOnDone: assert property (@(posedge clk) disable iff (!combin_res)
        (frameParity != $past(frameParity)) |-> frameDone)
        else begin
            failCount++;
            $error("frameParity changed without frameDone");
        end

endmodule

bind histogramTop histogramAsserts i_histogramAsserts (
    .clk         (clk),
    .combin_res  (combin_res),
    .frameDone   (frameDone),
    .frameParity (frameParity),
    .peakValid   (peakValid)
);
